/* mips_pipe_cfg.svh */
// configuration macros for the pipelined core
// widths, register count and reset PC
`ifndef MIPS_PIPE_CFG_SVH
`define MIPS_PIPE_CFG_SVH

// data and address width
`define MIPS_WORD_W 32

// register file size and index width
`define MIPS_REG_N 32
`define MIPS_REG_W 5

// immediate field of the I format
`define MIPS_IMM_W 16

// first fetch address after reset
`define MIPS_PC_INIT 32'h0000_0000

`endif

/* mips_pipe_pkg.sv */
// shared types of the pipelined core
// opcodes, ALU ops, instruction union and stage registers
`include "mips_pipe_cfg.svh"

package mips_pipe_pkg;

  typedef logic [`MIPS_WORD_W-1:0] word_t;
  typedef logic [`MIPS_REG_W-1:0]  reg_idx_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_e;

  typedef enum logic [5:0] {
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LOAD} wb_sel_e;
  typedef enum logic [1:0] {OPB_REG, OPB_SIMM, OPB_ZIMM} opb_sel_e;
  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} br_kind_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    logic [4:0] shamt;
    funct_e   funct;
  } r_fmt_s;

  // a J target is rs, rt and imm taken together
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    logic [`MIPS_IMM_W-1:0] imm;
  } i_fmt_s;

  typedef union packed {
    r_fmt_s r;
    i_fmt_s i;
  } instr_u;

  typedef struct packed {
    wb_sel_e  wb_sel;
    logic     ren;
    logic     wen;
    logic     halt;
    alu_op_e  alu_op;
    opb_sel_e opb_sel;
    br_kind_e br;
    word_t    rdat1;
    word_t    rdat2;
    logic [`MIPS_IMM_W-1:0] imm;
    reg_idx_t dest;
    word_t    npc;
  } exec_stage_s;

  typedef struct packed {
    wb_sel_e  wb_sel;
    reg_idx_t dest;
    word_t    alu_res;
    word_t    store;
    logic     ren;
    logic     wen;
    logic     halt;
  } mem_stage_s;

  typedef struct packed {
    wb_sel_e  wb_sel;
    reg_idx_t dest;
    word_t    wdat;
    logic     halt;
  } wb_stage_s;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dmem_req_s;

  typedef struct packed {
    logic     valid;
    reg_idx_t dest;
  } pending_s;

endpackage

/* fetch_unit.sv */
// fetch stage: PC, instruction register and next-PC choice
`include "mips_pipe_cfg.svh"

module fetch_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mips_pipe_pkg::word_t  imem_load,
  input  logic                  imem_hit,
  input  logic                  stall,
  input  logic                  mem_stall,
  input  logic                  jump,
  input  mips_pipe_pkg::word_t  jump_target,
  input  logic                  branch_taken,
  input  mips_pipe_pkg::word_t  branch_target,
  input  logic                  halted,
  output mips_pipe_pkg::word_t  imem_addr,
  output mips_pipe_pkg::instr_u instr,
  output mips_pipe_pkg::word_t  npc
);

  mips_pipe_pkg::word_t pc;
  logic br_in_decode;

  // no fetch past a branch until execute resolves it
  assign br_in_decode = (instr.i.opcode == mips_pipe_pkg::OP_BEQ) ||
                        (instr.i.opcode == mips_pipe_pkg::OP_BNE);

  assign imem_addr = pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc    <= `MIPS_PC_INIT;
      instr <= '0;
      npc   <= '0;
    end else if (!mem_stall) begin
      if (branch_taken) begin
        pc    <= branch_target;
        instr <= '0;
      end else if (stall) begin
        // interlock keeps the word in decode
        pc    <= pc;
      end else if (jump) begin
        pc    <= jump_target;
        instr <= '0;
      end else if (halted || br_in_decode || !imem_hit) begin
        instr <= '0;
      end else begin
        instr <= imem_load;
        npc   <= pc + 4;
        pc    <= pc + 4;
      end
    end
  end

  pc_aligned: assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00)
    else $error("fetch PC not word aligned: %h", pc);

endmodule

/* decode_unit.sv */
// decode stage: control generation, register read and RAW interlock
module decode_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  mips_pipe_pkg::instr_u      instr,
  input  mips_pipe_pkg::word_t       npc,
  input  mips_pipe_pkg::word_t       rdat1,
  input  mips_pipe_pkg::word_t       rdat2,
  input  mips_pipe_pkg::pending_s    exec_pending,
  input  mips_pipe_pkg::pending_s    mem_pending,
  input  mips_pipe_pkg::pending_s    wb_pending,
  input  logic                       mem_stall,
  input  logic                       branch_taken,
  output mips_pipe_pkg::reg_idx_t    rsel1,
  output mips_pipe_pkg::reg_idx_t    rsel2,
  output logic                       stall,
  output logic                       jump,
  output mips_pipe_pkg::word_t       jump_target,
  output logic                       halted,
  output mips_pipe_pkg::exec_stage_s exec_in
);

  mips_pipe_pkg::opcode_e     opcode;
  mips_pipe_pkg::exec_stage_s dec;
  logic use_rs, use_rt, rs_busy, rt_busy, halt_q;

  function automatic logic pend_hit(input mips_pipe_pkg::pending_s p,
                                    input mips_pipe_pkg::reg_idx_t r);
    return p.valid && (p.dest == r) && (r != '0);
  endfunction

  assign opcode = instr.i.opcode;
  assign rsel1  = instr.i.rs;
  assign rsel2  = instr.i.rt;

  always_comb begin
    dec         = '0;
    dec.rdat1   = rdat1;
    dec.rdat2   = rdat2;
    dec.imm     = instr.i.imm;
    dec.npc     = npc;
    dec.dest    = instr.i.rt;
    dec.opb_sel = mips_pipe_pkg::OPB_SIMM;
    dec.alu_op  = mips_pipe_pkg::ALU_ADD;
    dec.wb_sel  = mips_pipe_pkg::WB_ALU;
    use_rs      = 1'b1;
    use_rt      = 1'b0;
    case (opcode)
      mips_pipe_pkg::OP_RTYPE: begin
        dec.dest    = instr.r.rd;
        dec.opb_sel = mips_pipe_pkg::OPB_REG;
        use_rt      = 1'b1;
        case (instr.r.funct)
          mips_pipe_pkg::F_ADDU: dec.alu_op = mips_pipe_pkg::ALU_ADD;
          mips_pipe_pkg::F_SUBU: dec.alu_op = mips_pipe_pkg::ALU_SUB;
          mips_pipe_pkg::F_AND:  dec.alu_op = mips_pipe_pkg::ALU_AND;
          mips_pipe_pkg::F_OR:   dec.alu_op = mips_pipe_pkg::ALU_OR;
          mips_pipe_pkg::F_XOR:  dec.alu_op = mips_pipe_pkg::ALU_XOR;
          mips_pipe_pkg::F_SLT:  dec.alu_op = mips_pipe_pkg::ALU_SLT;
          default: begin
            // bubble or unsupported funct, acts as a nop
            dec.wb_sel = mips_pipe_pkg::WB_NONE;
            use_rs     = 1'b0;
            use_rt     = 1'b0;
          end
        endcase
      end
      mips_pipe_pkg::OP_ADDIU: dec.alu_op = mips_pipe_pkg::ALU_ADD;
      mips_pipe_pkg::OP_SLTI:  dec.alu_op = mips_pipe_pkg::ALU_SLT;
      mips_pipe_pkg::OP_ANDI, mips_pipe_pkg::OP_ORI, mips_pipe_pkg::OP_XORI: begin
        dec.opb_sel = mips_pipe_pkg::OPB_ZIMM;
        if (opcode == mips_pipe_pkg::OP_ANDI) dec.alu_op = mips_pipe_pkg::ALU_AND;
        else if (opcode == mips_pipe_pkg::OP_ORI) dec.alu_op = mips_pipe_pkg::ALU_OR;
        else dec.alu_op = mips_pipe_pkg::ALU_XOR;
      end
      mips_pipe_pkg::OP_LUI: begin
        dec.opb_sel = mips_pipe_pkg::OPB_ZIMM;
        dec.alu_op  = mips_pipe_pkg::ALU_LUI;
        use_rs      = 1'b0;
      end
      mips_pipe_pkg::OP_LW: begin
        dec.wb_sel = mips_pipe_pkg::WB_LOAD;
        dec.ren    = 1'b1;
      end
      mips_pipe_pkg::OP_SW, mips_pipe_pkg::OP_BEQ, mips_pipe_pkg::OP_BNE: begin
        dec.wb_sel = mips_pipe_pkg::WB_NONE;
        use_rt     = 1'b1;
        dec.wen    = (opcode == mips_pipe_pkg::OP_SW);
        if (opcode == mips_pipe_pkg::OP_BEQ) dec.br = mips_pipe_pkg::BR_EQ;
        if (opcode == mips_pipe_pkg::OP_BNE) dec.br = mips_pipe_pkg::BR_NE;
      end
      default: begin
        // J, HALT and unknown opcodes write nothing
        dec.wb_sel = mips_pipe_pkg::WB_NONE;
        dec.halt   = (opcode == mips_pipe_pkg::OP_HALT);
        use_rs     = 1'b0;
      end
    endcase
  end

  assign rs_busy = pend_hit(exec_pending, rsel1) || pend_hit(mem_pending, rsel1) ||
                   pend_hit(wb_pending, rsel1);
  assign rt_busy = pend_hit(exec_pending, rsel2) || pend_hit(mem_pending, rsel2) ||
                   pend_hit(wb_pending, rsel2);
  assign stall   = (use_rs && rs_busy) || (use_rt && rt_busy);

  assign jump        = (opcode == mips_pipe_pkg::OP_J);
  assign jump_target = {npc[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};
  assign halted      = halt_q || (opcode == mips_pipe_pkg::OP_HALT);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exec_in <= '0;
      halt_q  <= 1'b0;
    end else if (!mem_stall) begin
      exec_in <= (stall || branch_taken || halt_q) ? '0 : dec;
      if (dec.halt && !branch_taken) begin
        halt_q <= 1'b1;
      end
    end
  end

  no_stall_jump: assert property (@(posedge CLK) disable iff (!nRST) !(stall && jump))
    else $error("interlock stall raised together with a jump");

endmodule

/* register_file.sv */
// 32 x 32-bit register file, register 0 reads as zero
`include "mips_pipe_cfg.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  mips_pipe_pkg::reg_idx_t wsel,
  input  mips_pipe_pkg::word_t    wdat,
  input  mips_pipe_pkg::reg_idx_t rsel1,
  input  mips_pipe_pkg::reg_idx_t rsel2,
  output mips_pipe_pkg::word_t    rdat1,
  output mips_pipe_pkg::word_t    rdat2
);

  mips_pipe_pkg::word_t regs [`MIPS_REG_N];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin
      // register 0 never takes a write
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

/* execute_unit.sv */
// execute stage: operand select, ALU, branch resolution
// and the execute-to-memory register
`include "mips_pipe_cfg.svh"

module execute_unit (
  input  logic                       CLK,
  input  logic                       nRST,
  input  mips_pipe_pkg::exec_stage_s exec_in,
  input  logic                       mem_stall,
  output logic                       branch_taken,
  output mips_pipe_pkg::word_t       branch_target,
  output mips_pipe_pkg::pending_s    exec_pending,
  output mips_pipe_pkg::mem_stage_s  mem_in
);

  mips_pipe_pkg::word_t simm, zimm, opb, alu_res;
  logic ops_equal;

  assign simm = {{(`MIPS_WORD_W-`MIPS_IMM_W){exec_in.imm[`MIPS_IMM_W-1]}}, exec_in.imm};
  assign zimm = {{(`MIPS_WORD_W-`MIPS_IMM_W){1'b0}}, exec_in.imm};

  always_comb begin
    case (exec_in.opb_sel)
      mips_pipe_pkg::OPB_SIMM: opb = simm;
      mips_pipe_pkg::OPB_ZIMM: opb = zimm;
      default:                 opb = exec_in.rdat2;
    endcase
  end

  always_comb begin
    case (exec_in.alu_op)
      mips_pipe_pkg::ALU_SUB: alu_res = exec_in.rdat1 - opb;
      mips_pipe_pkg::ALU_AND: alu_res = exec_in.rdat1 & opb;
      mips_pipe_pkg::ALU_OR:  alu_res = exec_in.rdat1 | opb;
      mips_pipe_pkg::ALU_XOR: alu_res = exec_in.rdat1 ^ opb;
      mips_pipe_pkg::ALU_SLT: begin
        alu_res = {{(`MIPS_WORD_W-1){1'b0}}, $signed(exec_in.rdat1) < $signed(opb)};
      end
      mips_pipe_pkg::ALU_LUI: begin
        alu_res = {opb[`MIPS_IMM_W-1:0], {(`MIPS_WORD_W-`MIPS_IMM_W){1'b0}}};
      end
      default:                alu_res = exec_in.rdat1 + opb;
    endcase
  end

  // branches compare both register values directly
  assign ops_equal     = (exec_in.rdat1 == exec_in.rdat2);
  assign branch_taken  = ((exec_in.br == mips_pipe_pkg::BR_EQ) && ops_equal) ||
                         ((exec_in.br == mips_pipe_pkg::BR_NE) && !ops_equal);
  assign branch_target = exec_in.npc + {simm[`MIPS_WORD_W-3:0], 2'b00};

  assign exec_pending.valid = (exec_in.wb_sel != mips_pipe_pkg::WB_NONE);
  assign exec_pending.dest  = exec_in.dest;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_in <= '0;
    end else if (!mem_stall) begin
      mem_in.wb_sel  <= exec_in.wb_sel;
      mem_in.dest    <= exec_in.dest;
      mem_in.alu_res <= alu_res;
      mem_in.store   <= exec_in.rdat2;
      mem_in.ren     <= exec_in.ren;
      mem_in.wen     <= exec_in.wen;
      mem_in.halt    <= exec_in.halt;
    end
  end

endmodule

/* memory_writeback.sv */
// memory and write-back stages: data request, hold until hit,
// write-back register, register write and halt
module memory_writeback (
  input  logic                      CLK,
  input  logic                      nRST,
  input  mips_pipe_pkg::mem_stage_s mem_in,
  input  mips_pipe_pkg::word_t      dmem_load,
  input  logic                      dmem_hit,
  output mips_pipe_pkg::dmem_req_s  dmem_req,
  output logic                      mem_stall,
  output mips_pipe_pkg::pending_s   mem_pending,
  output mips_pipe_pkg::pending_s   wb_pending,
  output logic                      rf_wen,
  output mips_pipe_pkg::reg_idx_t   rf_wsel,
  output mips_pipe_pkg::word_t      rf_wdat,
  output logic                      halt
);

  mips_pipe_pkg::wb_stage_s wb;
  logic mem_access, acked;

  // one quiet cycle after every accepted request
  assign mem_access     = mem_in.ren || mem_in.wen;
  assign dmem_req.ren   = mem_in.ren && !acked;
  assign dmem_req.wen   = mem_in.wen && !acked;
  assign dmem_req.addr  = mem_in.alu_res;
  assign dmem_req.store = mem_in.store;
  assign mem_stall      = mem_access && (acked || !dmem_hit);

  assign mem_pending.valid = (mem_in.wb_sel != mips_pipe_pkg::WB_NONE);
  assign mem_pending.dest  = mem_in.dest;
  assign wb_pending.valid  = (wb.wb_sel != mips_pipe_pkg::WB_NONE);
  assign wb_pending.dest   = wb.dest;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      acked <= 1'b0;
      wb    <= '0;
      halt  <= 1'b0;
    end else begin
      acked <= dmem_hit && (dmem_req.ren || dmem_req.wen);
      halt  <= halt || wb.halt;
      if (mem_stall) begin
        wb <= '0;
      end else begin
        wb.wb_sel <= mem_in.wb_sel;
        wb.dest   <= mem_in.dest;
        wb.wdat   <= (mem_in.wb_sel == mips_pipe_pkg::WB_LOAD) ? dmem_load : mem_in.alu_res;
        wb.halt   <= mem_in.halt;
      end
    end
  end

  assign rf_wen  = (wb.wb_sel != mips_pipe_pkg::WB_NONE);
  assign rf_wsel = wb.dest;
  assign rf_wdat = wb.wdat;

  req_one_hot: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen))
    else $error("data request with ren and wen both high");

  req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_req.ren || dmem_req.wen) && !dmem_hit |=> $stable(dmem_req))
    else $error("data request changed while waiting for a hit");

endmodule

/* mips_pipe.sv */
// top level of the five-stage core
// fetch, decode, register file, execute, memory and write-back
module mips_pipe (
  input  logic                     CLK,
  input  logic                     nRST,
  output mips_pipe_pkg::word_t     imem_addr,
  input  mips_pipe_pkg::word_t     imem_load,
  input  logic                     imem_hit,
  output mips_pipe_pkg::dmem_req_s dmem_req,
  input  mips_pipe_pkg::word_t     dmem_load,
  input  logic                     dmem_hit,
  output logic                     halt
);

  mips_pipe_pkg::instr_u      instr;
  mips_pipe_pkg::word_t       npc, jump_target, branch_target;
  mips_pipe_pkg::word_t       rdat1, rdat2, rf_wdat;
  mips_pipe_pkg::reg_idx_t    rsel1, rsel2, rf_wsel;
  mips_pipe_pkg::pending_s    exec_pending, mem_pending, wb_pending;
  mips_pipe_pkg::exec_stage_s exec_in;
  mips_pipe_pkg::mem_stage_s  mem_in;
  logic stall, mem_stall, jump, branch_taken, halted, rf_wen;

  fetch_unit u_fetch (
    .CLK, .nRST, .imem_load, .imem_hit, .stall, .mem_stall, .jump, .jump_target,
    .branch_taken, .branch_target, .halted, .imem_addr, .instr, .npc
  );

  decode_unit u_decode (
    .CLK, .nRST, .instr, .npc, .rdat1, .rdat2, .exec_pending, .mem_pending,
    .wb_pending, .mem_stall, .branch_taken, .rsel1, .rsel2, .stall, .jump,
    .jump_target, .halted, .exec_in
  );

  register_file u_regs (
    .CLK, .nRST, .wen(rf_wen), .wsel(rf_wsel), .wdat(rf_wdat),
    .rsel1, .rsel2, .rdat1, .rdat2
  );

  execute_unit u_execute (
    .CLK, .nRST, .exec_in, .mem_stall, .branch_taken, .branch_target,
    .exec_pending, .mem_in
  );

  memory_writeback u_mem_wb (
    .CLK, .nRST, .mem_in, .dmem_load, .dmem_hit, .dmem_req, .mem_stall,
    .mem_pending, .wb_pending, .rf_wen, .rf_wsel, .rf_wdat, .halt
  );

endmodule

/* mips_pipe_tb.sv */
// clock, reset, memory models and program ROM for the pipelined core
// ISA reference model, assertions and watchdog
`include "mips_pipe_cfg.svh"

module mips_pipe_tb;

  localparam int PROG_LEN = 41;
  localparam int WATCHDOG = (PROG_LEN * 20 + 4) * 100;

  logic                     CLK = 1'b0;
  logic                     nRST;
  logic [31:0]              imem_addr;
  logic [31:0]              imem_load = '0;
  logic                     imem_hit = 1'b0;
  mips_pipe_pkg::dmem_req_s dmem_req;
  logic [31:0]              dmem_load = '0;
  logic                     dmem_hit = 1'b0;
  logic                     halt;

  logic [31:0] rom [64];
  logic [31:0] dmem [256];
  logic [31:0] exp_addr [64];
  logic [31:0] exp_data [64];
  int          exp_count;
  int          store_idx = 0;
  logic [31:0] imem_last = 32'hffff_ffff;
  int          imem_wait = 0;
  int          dmem_wait = 0;
  logic        dmem_busy = 1'b0;

  mips_pipe u_mips_pipe (
    .CLK, .nRST, .imem_addr, .imem_load, .imem_hit, .dmem_req, .dmem_load,
    .dmem_hit, .halt
  );

  always #50 CLK = ~CLK;

  task automatic end_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_error(input string why);
    $display("%0t: %s", $time, why);
    end_failed();
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp_v, act_v);
    end_failed();
  endtask

  // initial data memory contents
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h0101_0101) ^ 32'h5ac3_0f96;
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      rom[i] = {mips_pipe_pkg::OP_HALT, 26'd0};
    end
    rom[0]  = enc_i(mips_pipe_pkg::OP_ADDIU, 1, 0, 16'h0040);
    rom[1]  = enc_i(mips_pipe_pkg::OP_ADDIU, 2, 0, 16'hfffb);
    rom[2]  = enc_i(mips_pipe_pkg::OP_ORI, 3, 0, 16'h1234);
    // dependent chain straight after the writers
    rom[3]  = enc_r(mips_pipe_pkg::F_ADDU, 4, 2, 3);
    rom[4]  = enc_i(mips_pipe_pkg::OP_SW, 4, 1, 16'd0);
    rom[5]  = enc_r(mips_pipe_pkg::F_SUBU, 5, 3, 2);
    rom[6]  = enc_i(mips_pipe_pkg::OP_SW, 5, 1, 16'd4);
    rom[7]  = enc_r(mips_pipe_pkg::F_AND, 6, 3, 2);
    rom[8]  = enc_i(mips_pipe_pkg::OP_SW, 6, 1, 16'd8);
    rom[9]  = enc_r(mips_pipe_pkg::F_OR, 7, 3, 2);
    rom[10] = enc_i(mips_pipe_pkg::OP_SW, 7, 1, 16'd12);
    rom[11] = enc_r(mips_pipe_pkg::F_XOR, 8, 3, 2);
    rom[12] = enc_i(mips_pipe_pkg::OP_SW, 8, 1, 16'd16);
    rom[13] = enc_r(mips_pipe_pkg::F_SLT, 9, 2, 3);
    rom[14] = enc_i(mips_pipe_pkg::OP_SW, 9, 1, 16'd20);
    rom[15] = enc_i(mips_pipe_pkg::OP_ANDI, 10, 2, 16'hff0f);
    rom[16] = enc_i(mips_pipe_pkg::OP_SW, 10, 1, 16'd24);
    rom[17] = enc_i(mips_pipe_pkg::OP_XORI, 11, 3, 16'hffff);
    rom[18] = enc_i(mips_pipe_pkg::OP_SW, 11, 1, 16'd28);
    rom[19] = enc_i(mips_pipe_pkg::OP_SLTI, 12, 3, 16'h2000);
    rom[20] = enc_i(mips_pipe_pkg::OP_SW, 12, 1, 16'd32);
    rom[21] = enc_i(mips_pipe_pkg::OP_LUI, 13, 0, 16'hbeef);
    rom[22] = enc_i(mips_pipe_pkg::OP_SW, 13, 1, 16'd36);
    // load then immediate use
    rom[23] = enc_i(mips_pipe_pkg::OP_LW, 14, 0, 16'h0100);
    rom[24] = enc_r(mips_pipe_pkg::F_ADDU, 15, 14, 14);
    rom[25] = enc_i(mips_pipe_pkg::OP_SW, 15, 1, 16'd40);
    rom[26] = enc_i(mips_pipe_pkg::OP_SW, 14, 1, 16'd44);
    rom[27] = enc_i(mips_pipe_pkg::OP_BEQ, 4, 4, 16'd1);
    rom[28] = enc_i(mips_pipe_pkg::OP_SW, 0, 1, 16'd48);
    rom[29] = enc_i(mips_pipe_pkg::OP_BNE, 4, 4, 16'd1);
    rom[30] = enc_i(mips_pipe_pkg::OP_SW, 3, 1, 16'd52);
    rom[31] = enc_i(mips_pipe_pkg::OP_BNE, 5, 4, 16'd1);
    rom[32] = enc_i(mips_pipe_pkg::OP_SW, 0, 1, 16'd56);
    rom[33] = enc_i(mips_pipe_pkg::OP_BEQ, 5, 4, 16'd1);
    rom[34] = enc_i(mips_pipe_pkg::OP_SW, 2, 1, 16'd60);
    rom[35] = {mips_pipe_pkg::OP_J, 26'd37};
    rom[36] = enc_i(mips_pipe_pkg::OP_SW, 0, 1, 16'd64);
    rom[37] = enc_i(mips_pipe_pkg::OP_LW, 16, 1, 16'd4);
    rom[38] = enc_i(mips_pipe_pkg::OP_SW, 16, 1, 16'd68);
    rom[39] = {mips_pipe_pkg::OP_HALT, 26'd0};
    rom[40] = enc_i(mips_pipe_pkg::OP_SW, 0, 1, 16'd72);
  endtask

  // ISA-level run of the program that collects the expected stores
  task automatic run_reference();
    logic [31:0] regs [32];
    logic [31:0] ref_mem [256];
    logic [31:0] pc, w, a, b, simm, zimm, res, npc;
    logic [5:0]  op;
    logic [4:0]  rd;
    logic        wr, done;
    int          steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i * 4);
    pc = `MIPS_PC_INIT;
    done = 1'b0;
    steps = 0;
    exp_count = 0;
    while (!done && steps < 1000) begin
      w    = rom[pc[7:2]];
      op   = w[31:26];
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      simm = {{16{w[15]}}, w[15:0]};
      zimm = {16'd0, w[15:0]};
      npc  = pc + 4;
      rd   = w[20:16];
      wr   = 1'b1;
      res  = '0;
      case (op)
        mips_pipe_pkg::OP_RTYPE: begin
          rd = w[15:11];
          case (w[5:0])
            mips_pipe_pkg::F_ADDU: res = a + b;
            mips_pipe_pkg::F_SUBU: res = a - b;
            mips_pipe_pkg::F_AND:  res = a & b;
            mips_pipe_pkg::F_OR:   res = a | b;
            mips_pipe_pkg::F_XOR:  res = a ^ b;
            mips_pipe_pkg::F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            default:               wr = 1'b0;
          endcase
        end
        mips_pipe_pkg::OP_ADDIU: res = a + simm;
        mips_pipe_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
        mips_pipe_pkg::OP_ANDI:  res = a & zimm;
        mips_pipe_pkg::OP_ORI:   res = a | zimm;
        mips_pipe_pkg::OP_XORI:  res = a ^ zimm;
        mips_pipe_pkg::OP_LUI:   res = {w[15:0], 16'd0};
        mips_pipe_pkg::OP_LW:    res = ref_mem[(a + simm) >> 2];
        mips_pipe_pkg::OP_SW: begin
          wr = 1'b0;
          ref_mem[(a + simm) >> 2] = b;
          exp_addr[exp_count] = a + simm;
          exp_data[exp_count] = b;
          exp_count++;
        end
        mips_pipe_pkg::OP_BEQ: begin
          wr = 1'b0;
          if (a == b) npc = pc + 4 + {simm[29:0], 2'b00};
        end
        mips_pipe_pkg::OP_BNE: begin
          wr = 1'b0;
          if (a != b) npc = pc + 4 + {simm[29:0], 2'b00};
        end
        mips_pipe_pkg::OP_J: begin
          wr = 1'b0;
          npc = {npc[31:28], w[25:0], 2'b00};
        end
        default: begin
          wr = 1'b0;
          done = 1'b1;
        end
      endcase
      if (wr && rd != 5'd0) regs[rd] = res;
      pc = npc;
      steps++;
    end
  endtask

  // instruction memory with a new random delay per address
  always @(negedge CLK) begin
    if (imem_addr != imem_last) begin
      imem_last = imem_addr;
      imem_wait = $urandom % 4;
    end
    if (imem_wait == 0) begin
      imem_hit  = 1'b1;
      imem_load = rom[imem_addr[7:2]];
    end else begin
      imem_hit = 1'b0;
      imem_wait--;
    end
  end

  // data memory with a new random delay per request
  always @(negedge CLK) begin
    if (!(dmem_req.ren || dmem_req.wen)) begin
      dmem_busy = 1'b0;
      dmem_hit  = 1'b0;
    end else begin
      if (!dmem_busy) begin
        dmem_busy = 1'b1;
        dmem_wait = $urandom % 4;
      end
      if (dmem_wait == 0) begin
        dmem_hit  = 1'b1;
        dmem_load = dmem[dmem_req.addr[9:2]];
      end else begin
        dmem_hit = 1'b0;
        dmem_wait--;
      end
    end
  end

  always @(posedge CLK) begin
    if (nRST && dmem_req.wen && dmem_hit) begin
      dmem[dmem_req.addr[9:2]] = dmem_req.store;
      store_idx <= store_idx + 1;
    end
  end

  reset_idle: assert property (@(posedge CLK) (!nRST || $rose(nRST)) |->
    (!dmem_req.ren && !dmem_req.wen && !halt))
    else report_error("request strobe or halt active around reset");

  reset_pc: assert property (@(posedge CLK) (!nRST || $rose(nRST)) |->
    imem_addr == `MIPS_PC_INIT)
    else report_mismatch("imem_addr", `MIPS_PC_INIT, $sampled(imem_addr));

  store_in_list: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_req.wen && dmem_hit) |-> store_idx < exp_count)
    else report_error("store accepted beyond the expected store list");

  store_addr: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_req.wen && dmem_hit) |-> dmem_req.addr == exp_addr[store_idx])
    else report_mismatch("dmem_req.addr", exp_addr[$sampled(store_idx)],
                         $sampled(dmem_req.addr));

  store_data: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_req.wen && dmem_hit) |-> dmem_req.store == exp_data[store_idx])
    else report_mismatch("dmem_req.store", exp_data[$sampled(store_idx)],
                         $sampled(dmem_req.store));

  req_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen))
    else report_error("ren and wen high in the same cycle");

  req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    ((dmem_req.ren || dmem_req.wen) && !dmem_hit) |=> $stable(dmem_req))
    else report_error("data request changed before its hit");

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else report_error("halt dropped after rising");

  halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !(dmem_req.ren || dmem_req.wen))
    else report_error("data request after halt");

  halt_count: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(halt) |-> store_idx == exp_count)
    else report_mismatch("store count", exp_count, $sampled(store_idx));

  initial begin
    nRST = 1'b0;
    void'($urandom(32'hac5c));
    load_program();
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(i * 4);
    run_reference();
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    while (!halt) @(posedge CLK);
    // a few more cycles so the halt checks see a quiet bus
    repeat (6) @(posedge CLK);
    if (store_idx == exp_count) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_mismatch("store count", exp_count, store_idx);
    end
  end

  initial begin
    #(WATCHDOG);
    report_error("watchdog expired before halt");
  end

endmodule

/* mips_pipe.f */
+incdir+.
mips_pipe_pkg.sv
fetch_unit.sv
decode_unit.sv
register_file.sv
execute_unit.sv
memory_writeback.sv
mips_pipe.sv
mips_pipe_tb.sv

/* Makefile */
.PHONY: compile run clean

SIM = obj_dir/mips_pipe_sim

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module mips_pipe_tb \
		-f mips_pipe.f -o mips_pipe_sim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir
